// File: Makefile
# Verilator build and run for the multiply unit testbench
# override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tbExMulUnit
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= TESTS PASSED

SIM_EXE := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_EXE)

$(SIM_EXE): $(SOURCES) $(FILELIST) exMul_macros.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail, not the simulator exit code
run: compile
	-$(SIM_EXE) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: exCsAdd64.sv
// 64-bit carry-select adder, purely combinational
// carry-in is zero and the carry-out is dropped, so the sum wraps mod 2^64
`timescale 1ns/1ps

module exCsAdd64(
	input  logic [63:0] a,
	input  logic [63:0] b,
	output logic [63:0] sum
);

	// lowest block, plain ripple add
	logic [16:0] lowSum;
	// carry into blocks 1 to 3
	logic [3:1]  carry;

	assign lowSum = {1'b0, a[15:0]} + {1'b0, b[15:0]};
	assign sum[15:0] = lowSum[15:0];
	assign carry[1] = lowSum[16];

	genvar blk;
	for (blk = 1; blk < 4; blk++)
	begin : gBlock
		// both candidate sums are built in parallel
		logic [16:0] sumC0;
		logic [16:0] sumC1;

		assign sumC0 = {1'b0, a[blk*16 +: 16]} + {1'b0, b[blk*16 +: 16]};
		assign sumC1 = {1'b0, a[blk*16 +: 16]} + {1'b0, b[blk*16 +: 16]} + 17'd1;

		// carry from below picks the candidate
		assign sum[blk*16 +: 16] = carry[blk] ? sumC1[15:0] : sumC0[15:0];

		// top block carry-out falls off the word
		if (blk < 3)
		begin : gCarry
			assign carry[blk+1] = carry[blk] ? sumC1[16] : sumC0[16];
		end
	end

endmodule

// File: exMulCore.sv
// two-stage 32x32 multiplier with accumulate, held as a whole by exHold
// only bits 31..0 of valRs and valRt are used
// datapath registers have no reset, output is garbage until the first issue
// valRn is combinational from the stage-2 registers
`timescale 1ns/1ps

module exMulCore(
	input  logic             clock,
	input  logic [63:0]      valRs,
	input  logic [63:0]      valRt,
	input  logic [63:0]      valRm,
	input  exMulPkg::mulOp   idUOp,
	input  logic             exHold,
	output logic [63:0]      valRn
);

	// true for the ops that read their operands as signed
	function automatic logic isSignedOp(input exMulPkg::mulOp op);
		case (op)
			exMulPkg::opMulsLow,
			exMulPkg::opMuls,
			exMulPkg::opMacs:
				isSignedOp = 1'b1;
			default:
				isSignedOp = 1'b0;
		endcase
	endfunction

	// issue side, before stage 1
	logic [31:0] opA;
	logic [31:0] opB;
	logic        signedIn;
	logic [15:0] sxA;
	logic [15:0] sxB;
	logic [15:0] corrIn;
	logic [63:0] accIn;

	// stage 1 registers
	logic [31:0]    mulLL1;
	logic [31:0]    mulLH1;
	logic [31:0]    mulHL1;
	logic [31:0]    mulHH1;
	logic [15:0]    corr1;
	logic [63:0]    acc1;
	exMulPkg::mulOp op1;

	// between stage 1 and stage 2
	logic        signed1;
	logic [63:0] crossA;
	logic [63:0] crossB;
	logic [63:0] crossSum;
	logic [63:0] crossAcc;
	logic [63:0] prodIn;

	// stage 2 registers
	logic [63:0]    crossAcc2;
	logic [63:0]    prod2;
	exMulPkg::mulOp op2;

	// after stage 2
	logic [63:0] fullSum;

	always_comb
	begin
		opA = valRs[31:0];
		opB = valRt[31:0];
		signedIn = isSignedOp(idUOp);

		// upper halves widened with their sign for the cross terms
		sxA = (signedIn && opA[31]) ? 16'hFFFF : 16'h0000;
		sxB = (signedIn && opB[31]) ? 16'hFFFF : 16'h0000;

		// hi*hi is taken unsigned, so subtract the sign weight at bit 48
		// a15*b15 term would land at bit 64 and drops out
		corrIn = 16'h0000;
		if (signedIn && opA[31])
			corrIn = corrIn - opB[31:16];
		if (signedIn && opB[31])
			corrIn = corrIn - opA[31:16];

		// accumulator only for the mac forms
		if (idUOp == exMulPkg::opMacs || idUOp == exMulPkg::opMacu)
			accIn = valRm;
		else
			accIn = 64'h0;
	end

	// stage 1, partial products
	always_ff @(posedge clock)
	begin
		if (!exHold)
		begin
			mulLL1 <= opA[15:0] * opB[15:0];
			// cross terms, result fits in 32 bits signed or unsigned
			mulLH1 <= {16'h0000, opA[15:0]} * {sxB, opB[31:16]};
			mulHL1 <= {sxA, opA[31:16]} * {16'h0000, opB[15:0]};
			mulHH1 <= opA[31:16] * opB[31:16];
			corr1  <= corrIn;
			acc1   <= accIn;
			op1    <= idUOp;
		end
	end

	always_comb
	begin
		signed1 = isSignedOp(op1);

		// cross products sit at bit 16, sign-extended above when signed
		crossA = {{16{signed1 & mulLH1[31]}}, mulLH1, 16'h0000};
		crossB = {{16{signed1 & mulHL1[31]}}, mulHL1, 16'h0000};

		// hi*hi at bit 32 and lo*lo at bit 0 do not overlap
		// correction folds into the top 16 bits
		prodIn = {mulHH1[31:16] + corr1, mulHH1[15:0], mulLL1};
	end

	exCsAdd64 crossAdd(
		.a   (crossA),
		.b   (crossB),
		.sum (crossSum)
	);

	// accumulator merged here so the last stage needs one add
	exCsAdd64 accAdd(
		.a   (crossSum),
		.b   (acc1),
		.sum (crossAcc)
	);

	// stage 2
	always_ff @(posedge clock)
	begin
		if (!exHold)
		begin
			crossAcc2 <= crossAcc;
			prod2     <= prodIn;
			op2       <= op1;
		end
	end

	exCsAdd64 finalAdd(
		.a   (prod2),
		.b   (crossAcc2),
		.sum (fullSum)
	);

	// low forms replace the upper word with an extension of bit 31
	always_comb
	begin
		case (op2)
			exMulPkg::opMulsLow:
				valRn = {{32{fullSum[31]}}, fullSum[31:0]};
			exMulPkg::opMuluLow:
				valRn = {32'h0, fullSum[31:0]};
			default:
				valRn = fullSum;
		endcase
	end

endmodule

// File: exMulPkg.sv
// shared types for the execute-stage multiply unit
// unit command values other than cmdMul count as no operation
package exMulPkg;

	// execute unit command, only the multiply unit is decoded here
	typedef enum logic [3:0]
	{
		cmdNone = 4'h0,
		cmdMul  = 4'h1
	} exUnitCmd;

	// multiply operation
	// low forms give bits 31..0 extended to 64
	// mac forms add valRm to the full product
	typedef enum logic [2:0]
	{
		opMulsLow = 3'd0,
		opMuluLow = 3'd1,
		opMuls    = 3'd2,
		opMulu    = 3'd3,
		opMacs    = 3'd4,
		opMacu    = 3'd5
	} mulOp;

endpackage

// File: exMulTagPipe.sv
// valid bit and destination index beside the multiply datapath
// depth follows MUL_LATENCY and must stay in step with exMulCore
// any command other than cmdMul issues nothing
`timescale 1ns/1ps
`include "exMul_macros.svh"

module exMulTagPipe(
	input  logic                        clock,
	input  logic                        reset,
	input  exMulPkg::exUnitCmd          idUCmd,
	input  logic [`REG_INDEX_WIDTH-1:0] idRn,
	input  logic                        exHold,
	output logic                        resultValid,
	output logic [`REG_INDEX_WIDTH-1:0] resultRn
);

	// entry 0 loads at issue, last entry drives the outputs
	logic [`MUL_LATENCY-1:0]     validPipe;
	logic [`REG_INDEX_WIDTH-1:0] rnPipe [`MUL_LATENCY];
	logic                        issue;

	assign issue = (idUCmd == exMulPkg::cmdMul);

	// valid bits, cleared by reset even while held
	always_ff @(posedge clock)
	begin
		if (reset)
			validPipe <= '0;
		else if (!exHold)
		begin
			validPipe[0] <= issue;
			for (int i = 1; i < `MUL_LATENCY; i++)
				validPipe[i] <= validPipe[i-1];
		end
	end

	// index only matters when its valid bit is set
	always_ff @(posedge clock)
	begin
		if (!exHold)
		begin
			rnPipe[0] <= idRn;
			for (int i = 1; i < `MUL_LATENCY; i++)
				rnPipe[i] <= rnPipe[i-1];
		end
	end

	assign resultValid = validPipe[`MUL_LATENCY-1];
	assign resultRn    = rnPipe[`MUL_LATENCY-1];

endmodule

// File: exMulUnit.sv
// multiply unit top, core datapath plus tag pipeline
// valRn is only meaningful while resultValid is high
// exHold freezes both halves together
`timescale 1ns/1ps
`include "exMul_macros.svh"

module exMulUnit(
	input  logic                        clock,
	input  logic                        reset,
	input  logic [63:0]                 valRs,
	input  logic [63:0]                 valRt,
	input  logic [63:0]                 valRm,
	input  exMulPkg::exUnitCmd          idUCmd,
	input  exMulPkg::mulOp              idUOp,
	input  logic [`REG_INDEX_WIDTH-1:0] idRn,
	input  logic                        exHold,
	output logic [63:0]                 valRn,
	output logic                        resultValid,
	output logic [`REG_INDEX_WIDTH-1:0] resultRn
);

	// datapath runs every non-held cycle, command not needed here
	exMulCore core(
		.clock  (clock),
		.valRs  (valRs),
		.valRt  (valRt),
		.valRm  (valRm),
		.idUOp  (idUOp),
		.exHold (exHold),
		.valRn  (valRn)
	);

	// tells writeback when and where the result lands
	exMulTagPipe tagPipe(
		.clock       (clock),
		.reset       (reset),
		.idUCmd      (idUCmd),
		.idRn        (idRn),
		.exHold      (exHold),
		.resultValid (resultValid),
		.resultRn    (resultRn)
	);

endmodule

// File: exMul_macros.svh
// fixed sizes for the multiply unit
// MUL_LATENCY must match the two register stages inside exMulCore
// REG_INDEX_WIDTH sets the destination index width seen by writeback
`ifndef EXMUL_MACROS_SVH
`define EXMUL_MACROS_SVH

// non-held edges from issue to result on valRn
`define MUL_LATENCY 2

// destination register index width
`define REG_INDEX_WIDTH 6

`endif

// File: list.f
+incdir+.
exMulPkg.sv
exCsAdd64.sv
exMulCore.sv
exMulTagPipe.sv
exMulUnit.sv
tbExMulUnit.sv

// File: tbExMulUnit.sv
// testbench for exMulUnit, random and corner operands from a fixed xorshift seed
// results are checked at the falling edge, inputs change 1 ns after the rising edge
// first error stops the run, a watchdog bounds the run time
`timescale 1ns/1ps
`include "exMul_macros.svh"

module tbExMulUnit;

	localparam int numCornerOps = 150;
	localparam int numRandomOps = 300;
	// 20 cycles of 100 ns per issued operation
	localparam longint watchdogNs = longint'(numCornerOps + numRandomOps) * 20 * 100;

	logic                        clock;
	logic                        reset;
	logic [63:0]                 valRs;
	logic [63:0]                 valRt;
	logic [63:0]                 valRm;
	exMulPkg::exUnitCmd          idUCmd;
	exMulPkg::mulOp              idUOp;
	logic [`REG_INDEX_WIDTH-1:0] idRn;
	logic                        exHold;
	logic [63:0]                 valRn;
	logic                        resultValid;
	logic [`REG_INDEX_WIDTH-1:0] resultRn;

	// expected results in issue order
	string                       nameQ [$];
	logic [63:0]                 valueQ [$];
	logic [`REG_INDEX_WIDTH-1:0] rnQ [$];
	int                          edgeQ [$];

	logic [31:0] rngState;
	int          issued = 0;
	// rising edges seen with exHold low
	int          liveEdges = 0;

	exMulUnit UUT(
		.clock       (clock),
		.reset       (reset),
		.valRs       (valRs),
		.valRt       (valRt),
		.valRm       (valRm),
		.idUCmd      (idUCmd),
		.idUOp       (idUOp),
		.idRn        (idRn),
		.exHold      (exHold),
		.valRn       (valRn),
		.resultValid (resultValid),
		.resultRn    (resultRn)
	);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock)
	begin
		if (!exHold)
			liveEdges <= liveEdges + 1;
	end

	task automatic stopWithError(input string line);
		$display("%s", line);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	// xorshift32
	function automatic logic [31:0] nextRand();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	function automatic exMulPkg::mulOp pickOp(input int unsigned sel);
		case (sel)
			0: pickOp = exMulPkg::opMulsLow;
			1: pickOp = exMulPkg::opMuluLow;
			2: pickOp = exMulPkg::opMuls;
			3: pickOp = exMulPkg::opMulu;
			4: pickOp = exMulPkg::opMacs;
			default: pickOp = exMulPkg::opMacu;
		endcase
	endfunction

	function automatic logic [31:0] cornerValue(input int unsigned idx);
		case (idx)
			0: cornerValue = 32'h0000_0000;
			1: cornerValue = 32'hFFFF_FFFF;
			2: cornerValue = 32'h8000_0000;
			3: cornerValue = 32'h0000_0001;
			default: cornerValue = 32'h7FFF_FFFF;
		endcase
	endfunction

	// product straight from the op definitions
	function automatic logic [63:0] modelResult(input exMulPkg::mulOp op,
		input logic [31:0] a, input logic [31:0] b, input logic [63:0] m);
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic [63:0]        full;
		logic               signedOp;
		signedOp = (op == exMulPkg::opMulsLow) || (op == exMulPkg::opMuls) ||
			(op == exMulPkg::opMacs);
		sa = signedOp ? {{32{a[31]}}, a} : {32'h0, a};
		sb = signedOp ? {{32{b[31]}}, b} : {32'h0, b};
		full = sa * sb;
		case (op)
			exMulPkg::opMulsLow: modelResult = {{32{full[31]}}, full[31:0]};
			exMulPkg::opMuluLow: modelResult = {32'h0, full[31:0]};
			exMulPkg::opMacs, exMulPkg::opMacu: modelResult = full + m;
			default: modelResult = full;
		endcase
	endfunction

	// one clock of stimulus, queued only when it really issues
	task automatic driveCycle(input string name, input logic doMul, input logic hold,
		input exMulPkg::mulOp op, input logic [63:0] rs, input logic [63:0] rt,
		input logic [63:0] rm, input logic [`REG_INDEX_WIDTH-1:0] rn);
		@(posedge clock);
		#1;
		valRs = rs;
		valRt = rt;
		valRm = rm;
		idUOp = op;
		idRn = rn;
		exHold = hold;
		// reserved command code 7 must behave like cmdNone
		idUCmd = doMul ? exMulPkg::cmdMul : exMulPkg::exUnitCmd'(rs[0] ? 4'h7 : 4'h0);
		if (doMul && !hold)
		begin
			nameQ.push_back(name);
			valueQ.push_back(modelResult(op, rs[31:0], rt[31:0], rm));
			rnQ.push_back(rn);
			edgeQ.push_back(liveEdges);
			issued++;
		end
	endtask

	// outputs settle well before the falling edge
	always @(negedge clock)
	begin
		if (!reset)
		begin
			assert (resultValid === 1'b0 || resultValid === 1'b1)
			else stopWithError("resultValid is unknown after reset");
			if (resultValid)
			begin
				assert (valueQ.size() != 0)
				else stopWithError("resultValid went high with no operation in flight");
				assert (liveEdges == edgeQ[0] + `MUL_LATENCY)
				else stopWithError($sformatf("Mismatch %s latency expected %0d actual %0d",
					nameQ[0], `MUL_LATENCY, liveEdges - edgeQ[0]));
				assert (resultRn === rnQ[0])
				else stopWithError($sformatf("Mismatch %s resultRn expected %0d actual %0d",
					nameQ[0], rnQ[0], resultRn));
				assert (valRn === valueQ[0])
				else stopWithError($sformatf("Mismatch %s valRn expected %h actual %h",
					nameQ[0], valueQ[0], valRn));
				// held result stays up and is checked again next cycle
				if (!exHold)
				begin
					void'(nameQ.pop_front());
					void'(valueQ.pop_front());
					void'(rnQ.pop_front());
					void'(edgeQ.pop_front());
				end
			end
		end
	end

	initial
	begin
		#(watchdogNs);
		stopWithError("watchdog expired before all results came back");
	end

	initial
	begin
		exMulPkg::mulOp op;
		logic [31:0]    r;
		rngState = 32'he723;
		reset = 1'b1;
		exHold = 1'b0;
		idUCmd = exMulPkg::cmdNone;
		idUOp = exMulPkg::opMuls;
		idRn = '0;
		valRs = 64'h0;
		valRt = 64'h0;
		valRm = 64'h0;
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;

		// idle after reset, any resultValid here is an error
		repeat (6)
			driveCycle("idle", 1'b0, 1'b0, exMulPkg::opMuls, 64'h0, 64'h0, 64'h0, '0);

		// corner operands, every op, back to back, garbage in the upper words
		for (int i = 0; i < 5; i++)
			for (int j = 0; j < 5; j++)
				for (int k = 0; k < 6; k++)
				begin
					op = pickOp(k);
					r = nextRand();
					driveCycle($sformatf("corner %s", op.name()), 1'b1, 1'b0, op,
						{nextRand(), cornerValue(i)}, {nextRand(), cornerValue(j)},
						{nextRand(), nextRand()}, r[`REG_INDEX_WIDTH-1:0]);
				end

		// random traffic with idle cycles and exHold pulses
		while (issued < numCornerOps + numRandomOps)
		begin
			r = nextRand();
			op = pickOp(r[15:8] % 6);
			driveCycle($sformatf("random %s", op.name()), r[1:0] != 2'd0, r[3:2] == 2'd0,
				op, {nextRand(), nextRand()}, {nextRand(), nextRand()},
				{nextRand(), nextRand()}, r[`REG_INDEX_WIDTH+19:20]);
		end

		// pipeline empties after MUL_LATENCY unheld edges
		repeat (`MUL_LATENCY)
			driveCycle("drain", 1'b0, 1'b0, exMulPkg::opMuls, 64'h0, 64'h0, 64'h0, '0);
		// a few idle cycles for stray results
		repeat (4)
			driveCycle("tail", 1'b0, 1'b0, exMulPkg::opMuls, 64'h0, 64'h0, 64'h0, '0);

		if (valueQ.size() == 0)
		begin
			$display("TESTS PASSED");
			$finish;
		end
		else
			stopWithError("expected results still queued at the end of the run");
	end

endmodule
